// File: list.f
rtl/tdc_link_pkg.sv
rtl/uart_byte_tx.sv
rtl/record_fifo.sv
rtl/record_serializer.sv
rtl/fifo_manager.sv
bench/uart_rx_model.sv
bench/tb_fifo_manager.sv

// File: bench/tb_fifo_manager.sv
`timescale 1ns/10ps

module tb_fifo_manager
    import tdc_link_pkg::*;
;

    localparam int SEED         = 15;
    localparam int CLK_PERIOD   = 10;
    localparam int RECORD_COUNT = 63;
    localparam int WATCHDOG_NS  = 2 * RECORD_COUNT * 60 * CLK_PER_BIT * CLK_PERIOD + 1000;

    logic                             clk;
    logic                             rst;
    logic [NUM_CH-1:0]                sample_req;
    logic [NUM_CH-1:0][PAYLOAD_W-1:0] sample_data;
    logic [NUM_CH-1:0]                line_req;
    logic [NUM_CH-1:0]                frame_req;
    logic [NUM_CH-1:0]                sample_done;
    logic [NUM_CH-1:0]                line_done;
    logic [NUM_CH-1:0]                frame_done;
    logic                             tx;
    logic                             tx_busy;

    logic                rx_valid;
    logic [RECORD_W-1:0] rx_rec;
    int                  frame_errors;

    logic [RECORD_W-1:0] exp_q[$];
    logic [3*NUM_CH-1:0] acked;
    logic [3*NUM_CH-1:0] mon_done;
    logic [3*NUM_CH-1:0] mon_exp;
    int                  mon_pick;
    int                  checks;
    int                  errors;
    int                  received;
    int                  issued;
    int                  kind;
    int                  ch;
    int unsigned         seed_dummy;

    fifo_manager i_fifo_manager (
        .clk         (clk),
        .rst         (rst),
        .sample_req  (sample_req),
        .sample_data (sample_data),
        .line_req    (line_req),
        .frame_req   (frame_req),
        .sample_done (sample_done),
        .line_done   (line_done),
        .frame_done  (frame_done),
        .tx          (tx),
        .tx_busy     (tx_busy)
    );

    uart_rx_model i_uart_rx_model (
        .clk          (clk),
        .tx           (tx),
        .rec_valid    (rx_valid),
        .rec          (rx_rec),
        .frame_errors (frame_errors)
    );

    // next grant as kind * NUM_CH + channel index
    // -1 when nothing is pending
    function automatic int next_grant(logic [NUM_CH-1:0] s, logic [NUM_CH-1:0] l,
                                      logic [NUM_CH-1:0] f);
        for (int c = 0; c < NUM_CH; c++) begin
            if (s[c]) return c;
            if (l[c]) return NUM_CH + c;
            if (f[c]) return 2 * NUM_CH + c;
        end
        return -1;
    endfunction

    // kind 0 is a sample, 1 a line marker, 2 a frame marker
    function automatic logic [RECORD_W-1:0] make_record(int k, int c,
                                                        logic [PAYLOAD_W-1:0] payload);
        logic [TAG_W-1:0] tag;
        tag = TAG_W'(c + 1);
        case (k)
            0:       return {payload, tag};
            1:       return {LINE_CODE, LINE_CODE, tag};
            default: return {FRAME_CODE, FRAME_CODE, tag};
        endcase
    endfunction

    task automatic check_value(string what, logic [RECORD_W-1:0] got,
                               logic [RECORD_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one falling edge where handshakes that saw done drop their request
    task automatic tick();
        @(negedge clk);
        sample_req = sample_req & ~acked[NUM_CH-1:0];
        line_req   = line_req & ~acked[2*NUM_CH-1:NUM_CH];
        frame_req  = frame_req & ~acked[3*NUM_CH-1:2*NUM_CH];
        acked      = '0;
    endtask

    function automatic logic is_pending(int k, int c);
        return (k == 0) ? sample_req[c] : (k == 1) ? line_req[c] : frame_req[c];
    endfunction

    task automatic raise_req(int k, int c, logic [PAYLOAD_W-1:0] payload);
        case (k)
            0: begin
                sample_data[c] = payload;
                sample_req[c]  = 1'b1;
            end
            1:       line_req[c]  = 1'b1;
            default: frame_req[c] = 1'b1;
        endcase
    endtask

    task automatic wait_drain();
        int limit;
        int n;
        limit = (exp_q.size() + $countones({frame_req, line_req, sample_req}) + 1)
                * 120 * CLK_PER_BIT;
        n = 0;
        while ((exp_q.size() != 0 || (sample_req | line_req | frame_req) != '0 || tx_busy)
               && n < limit) begin
            tick();
            n++;
        end
        repeat (2 * CLK_PER_BIT) tick();
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // grant monitor checks the done bits against the reference pick
    always @(posedge clk) begin
        if (!rst) begin
            mon_done = {frame_done, line_done, sample_done};
            if (mon_done != '0) begin
                mon_pick = next_grant(sample_req, line_req, frame_req);
                mon_exp  = '0;
                if (mon_pick >= 0) begin
                    mon_exp[mon_pick] = 1'b1;
                    exp_q.push_back(make_record(mon_pick / NUM_CH, mon_pick % NUM_CH,
                                                sample_data[mon_pick % NUM_CH]));
                end
                check_value("done bits", mon_done, mon_exp);
                acked = acked | mon_done;
            end
        end
    end

    // compare each received record with the oldest expected one
    always @(posedge clk) begin
        if (rx_valid) begin
            received++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("record %h arrived on tx without any grant", rx_rec);
            end else begin
                check_value("received record", rx_rec, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed_dummy  = $urandom(SEED);
        rst         = 1'b1;
        sample_req  = '0;
        sample_data = '0;
        line_req    = '0;
        frame_req   = '0;
        acked       = '0;
        checks      = 0;
        errors      = 0;
        received    = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle line after reset
        repeat (5) begin
            tick();
            check_value("idle tx", tx, 1'b1);
            check_value("idle tx_busy", tx_busy, 1'b0);
            check_value("idle done bits", {frame_done, line_done, sample_done}, '0);
        end

        // one sample per channel, granted at the first edge with an empty queue
        for (int c = 0; c < NUM_CH; c++) begin
            tick();
            raise_req(0, c, $urandom());
            tick();
            check_value("sample request after one edge", sample_req[c], 1'b0);
            wait_drain();
        end

        // line and frame markers per channel
        for (int c = 0; c < NUM_CH; c++) begin
            tick();
            raise_req(1, c, '0);
            raise_req(2, c, '0);
            wait_drain();
        end

        // mixed requests raised in one cycle
        tick();
        raise_req(0, 1, $urandom());
        raise_req(0, 3, $urandom());
        raise_req(1, 0, '0);
        raise_req(1, 2, '0);
        raise_req(1, 4, '0);
        raise_req(2, 0, '0);
        raise_req(2, 1, '0);
        raise_req(2, 4, '0);
        wait_drain();

        // burst deeper than the fifo while the line drains slowly
        issued = 0;
        while (issued < 40) begin
            tick();
            ch   = $urandom() % NUM_CH;
            kind = $urandom() % 3;
            if (!is_pending(kind, ch)) begin
                raise_req(kind, ch, $urandom());
                issued++;
            end
        end
        wait_drain();

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d granted records were never received on tx", exp_q.size());
        end
        check_value("records received", received, RECORD_COUNT);
        check_value("final tx_busy", tx_busy, 1'b0);
        errors = errors + frame_errors;
        $display("checks %0d, errors %0d, records received %0d", checks, errors, received);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: bench/uart_rx_model.sv
`timescale 1ns/10ps

module uart_rx_model
    import tdc_link_pkg::*;
(
    input  logic                clk,
    input  logic                tx,
    output logic                rec_valid,
    output logic [RECORD_W-1:0] rec,
    output int                  frame_errors
);

    logic [7:0]          data;
    logic [RECORD_W-1:0] shift;
    int                  nbytes;

    // samples on the falling clock edge, tx moves on the rising one
    initial begin
        rec_valid    = 1'b0;
        rec          = '0;
        frame_errors = 0;
        shift        = '0;
        nbytes       = 0;
        forever begin
            @(negedge clk);
            rec_valid = 1'b0;
            if (tx === 1'b0) begin
                // move to the middle of the start bit
                repeat (CLK_PER_BIT / 2) @(negedge clk);
                if (tx === 1'b0) begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (CLK_PER_BIT) @(negedge clk);
                        data[i] = tx;
                    end
                    repeat (CLK_PER_BIT) @(negedge clk);
                    if (tx !== 1'b1) begin
                        frame_errors++;
                        $display("uart model: stop bit missing at %0t", $time);
                    end
                    // first byte on the line is the top byte of the record
                    shift = {shift[RECORD_W-9:0], data};
                    nbytes++;
                    if (nbytes == BYTES_PER_RECORD) begin
                        nbytes    = 0;
                        rec       = shift;
                        rec_valid = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: rtl/fifo_manager.sv
`timescale 1ns/10ps

module fifo_manager
    import tdc_link_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,

    // per-channel requests, bit 0 is channel 1
    input  logic [NUM_CH-1:0]                 sample_req,
    input  logic [NUM_CH-1:0][PAYLOAD_W-1:0]  sample_data,
    input  logic [NUM_CH-1:0]                 line_req,
    input  logic [NUM_CH-1:0]                 frame_req,

    // grant acknowledges, high only in the grant cycle
    output logic [NUM_CH-1:0]                 sample_done,
    output logic [NUM_CH-1:0]                 line_done,
    output logic [NUM_CH-1:0]                 frame_done,

    output logic                              tx,
    output logic                              tx_busy
);

    logic        grant;
    tdc_record_u rec_next;

    // write side of the record queue
    logic        wr_en;
    tdc_record_u wr_data;
    logic        full;

    // read side of the record queue
    logic        rd_en;
    tdc_record_u rd_data;
    logic        empty;

    // high in the cycle between the read and busy rising
    logic        launch_pending;

    // fixed priority scan, lowest channel first
    // within a channel: sample, then line, then frame
    always_comb begin
        grant       = 1'b0;
        rec_next    = '0;
        sample_done = '0;
        line_done   = '0;
        frame_done  = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (!grant && !full) begin
                if (sample_req[ch]) begin
                    grant                  = 1'b1;
                    sample_done[ch]        = 1'b1;
                    rec_next.sample.payload = sample_data[ch];
                    rec_next.sample.tag     = TAG_W'(ch + 1);
                end else if (line_req[ch]) begin
                    grant                   = 1'b1;
                    line_done[ch]           = 1'b1;
                    rec_next.marker.code_hi = LINE_CODE;
                    rec_next.marker.code_lo = LINE_CODE;
                    rec_next.marker.tag     = TAG_W'(ch + 1);
                end else if (frame_req[ch]) begin
                    grant                   = 1'b1;
                    frame_done[ch]          = 1'b1;
                    rec_next.marker.code_hi = FRAME_CODE;
                    rec_next.marker.code_lo = FRAME_CODE;
                    rec_next.marker.tag     = TAG_W'(ch + 1);
                end
            end
        end
    end

    // granted record goes into the queue one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= grant;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            wr_data <= rec_next;
        end
    end

    // pop a record when the line is free and nothing is on its way
    assign rd_en = !empty && !tx_busy && !launch_pending;

    // rd_data is valid one cycle after rd_en, which is when start fires
    always_ff @(posedge clk) begin
        if (rst) begin
            launch_pending <= 1'b0;
        end else begin
            launch_pending <= rd_en;
        end
    end

    record_fifo i_record_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .empty   (empty),
        .full    (full)
    );

    record_serializer i_record_serializer (
        .clk   (clk),
        .rst   (rst),
        .start (launch_pending),
        .rec   (rd_data),
        .tx    (tx),
        .busy  (tx_busy)
    );

endmodule

// File: rtl/record_serializer.sv
`timescale 1ns/10ps

module record_serializer
    import tdc_link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  tdc_record_u rec,
    output logic        tx,
    output logic        busy
);

    // record held here, top byte is always the next to go
    logic [RECORD_W-1:0]   rec_sr;
    logic [BYTE_IDX_W-1:0] byte_idx;

    logic                  byte_start;
    logic [7:0]            byte_data;
    logic                  byte_busy;
    logic                  byte_busy_q;
    logic                  byte_done;

    assign byte_data = rec_sr[RECORD_W-1 -: 8];

    // falling edge of the byte transmitter busy
    assign byte_done = byte_busy_q && !byte_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            byte_start  <= 1'b0;
            byte_idx    <= '0;
            byte_busy_q <= 1'b0;
        end else begin
            byte_start  <= 1'b0;
            byte_busy_q <= byte_busy;
            if (!busy) begin
                if (start) begin
                    busy       <= 1'b1;
                    byte_start <= 1'b1;
                    byte_idx   <= '0;
                end
            end else if (byte_done) begin
                if (byte_idx == BYTE_IDX_W'(BYTES_PER_RECORD - 1)) begin
                    busy <= 1'b0;
                end else begin
                    byte_idx   <= byte_idx + 1'b1;
                    byte_start <= 1'b1;
                end
            end
        end
    end

    // msb first, shift up one byte after each completed byte
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            rec_sr <= rec;
        end else if (busy && byte_done) begin
            rec_sr <= rec_sr << 8;
        end
    end

    uart_byte_tx i_uart_byte_tx (
        .clk        (clk),
        .rst        (rst),
        .byte_start (byte_start),
        .byte_data  (byte_data),
        .tx         (tx),
        .byte_busy  (byte_busy)
    );

endmodule

// File: rtl/record_fifo.sv
`timescale 1ns/10ps

module record_fifo
    import tdc_link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  tdc_record_u wr_data,
    input  logic        rd_en,
    output tdc_record_u rd_data,
    output logic        empty,
    output logic        full
);

    tdc_record_u        mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    assign empty = (count == '0);
    // one entry early, the arbiter has a registered write in flight
    assign full  = (count >= (FIFO_AW + 1)'(FIFO_DEPTH - 1));

    assign do_wr = wr_en && (count != (FIFO_AW + 1)'(FIFO_DEPTH));
    assign do_rd = rd_en && !empty;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

// File: rtl/uart_byte_tx.sv
`timescale 1ns/10ps

module uart_byte_tx
    import tdc_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_start,
    input  logic [7:0] byte_data,
    output logic       tx,
    output logic       byte_busy
);

    // data bits followed by the stop bit, shifted out lsb first
    logic [8:0]           shift_reg;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_idx;
    logic                 bit_end;

    assign bit_end = (clk_cnt == CLK_CNT_W'(CLK_PER_BIT - 1));

    // bit_idx 0 is the start bit, 9 is the stop bit
    always_ff @(posedge clk) begin
        if (rst) begin
            tx        <= 1'b1;
            byte_busy <= 1'b0;
            clk_cnt   <= '0;
            bit_idx   <= '0;
        end else if (!byte_busy) begin
            tx <= 1'b1;
            if (byte_start) begin
                tx        <= 1'b0;
                byte_busy <= 1'b1;
                clk_cnt   <= '0;
                bit_idx   <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
                byte_busy <= 1'b0;
            end else begin
                tx      <= shift_reg[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!byte_busy && byte_start) begin
            shift_reg <= {1'b1, byte_data};
        end else if (byte_busy && bit_end) begin
            // fill with ones so the stop bit follows bit 7
            shift_reg <= {1'b1, shift_reg[8:1]};
        end
    end

endmodule

// File: rtl/tdc_link_pkg.sv
package tdc_link_pkg;

    // channel and record geometry
    localparam int NUM_CH           = 5;
    localparam int PAYLOAD_W        = 32;
    localparam int TAG_W            = 16;
    localparam int RECORD_W         = PAYLOAD_W + TAG_W;
    localparam int BYTES_PER_RECORD = RECORD_W / 8;
    localparam int BYTE_IDX_W       = $clog2(BYTES_PER_RECORD);

    // marker codes, sent twice above the tag
    localparam int CODE_W = 16;
    localparam logic [CODE_W-1:0] LINE_CODE  = 16'h000D;
    localparam logic [CODE_W-1:0] FRAME_CODE = 16'h000E;

    // uart bit timing, clocks per bit must be 2 or more
    localparam int CLK_PER_BIT = 8;
    localparam int CLK_CNT_W   = $clog2(CLK_PER_BIT);

    // record queue
    localparam int          FIFO_AW    = 4;
    localparam int unsigned FIFO_DEPTH = 2 ** FIFO_AW;

    // one 48-bit word, read as a timestamp sample or as a line/frame marker
    typedef union packed {
        struct packed {
            logic [PAYLOAD_W-1:0] payload;
            logic [TAG_W-1:0]     tag;
        } sample;
        struct packed {
            logic [CODE_W-1:0] code_hi;
            logic [CODE_W-1:0] code_lo;
            logic [TAG_W-1:0]  tag;
        } marker;
    } tdc_record_u;

endpackage
